/* sysbus_pkg.sv */
package sysbus_pkg;

	//////////////////////////////////////////////////////////////////////
	// Bus types
	//////////////////////////////////////////////////////////////////////

	// One master request, held stable until ack or err.
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [7:0]  sel;		// Byte lanes.
		logic [31:0] adr;
		logic [63:0] dat;		// Write data.
	} wb_req_t;

	typedef struct packed {
		logic        ack;
		logic        err;
		logic [63:0] dat;		// Read data, valid with ack.
	} wb_rsp_t;

	// The bus data word is taken as a whole or as two 32-bit halves.
	typedef union packed {
		logic [63:0]      word;
		logic [1:0][31:0] half;	// Index 0 is the low half.
	} bus_word_u;

	//////////////////////////////////////////////////////////////////////
	// Address map, compared against adr[31:16]
	//////////////////////////////////////////////////////////////////////

	localparam logic [15:0] RAM_BASE  = 16'h0000;
	localparam logic [15:0] ROM_BASE  = 16'h0001;
	localparam logic [15:0] TEXT_BASE = 16'hFFDC;

	//////////////////////////////////////////////////////////////////////
	// Memory sizes
	//////////////////////////////////////////////////////////////////////

	localparam int RAM_WORDS  = 2048;		// 64-bit words.
	localparam int ROM_WORDS  = 512;		// 64-bit words.
	localparam int TEXT_WORDS = 2048;		// 32-bit words.

	localparam int RAM_AW  = $clog2(RAM_WORDS);	// Word index adr[13:3].
	localparam int ROM_AW  = $clog2(ROM_WORDS);	// Word index adr[11:3].
	localparam int TEXT_AW = $clog2(TEXT_WORDS);	// Word index adr[12:2].

	localparam string ROM_FILE = "boot_rom.hex";

	//////////////////////////////////////////////////////////////////////
	// Masters
	//////////////////////////////////////////////////////////////////////

	localparam int N_MASTERS = 2;
	localparam int MID_W     = $clog2(N_MASTERS);

	typedef logic [MID_W-1:0] master_id_t;

endpackage

/* bus_arbiter.sv */
`timescale 1ns/10ps

module bus_arbiter import sysbus_pkg::*; (
	input  logic    clk,
	input  logic    rst_n_i,
	input  wb_req_t m0_req_i,
	input  wb_req_t m1_req_i,
	input  wb_rsp_t bus_rsp_i,
	output wb_req_t bus_req_o,
	output wb_rsp_t m0_rsp_o,
	output wb_rsp_t m1_rsp_o
);

	logic       own_vld_q;
	master_id_t owner_q;
	master_id_t last_q;
	master_id_t grant;
	logic       owner_cyc;

	//////////////////////////////////////////////////////////////////////
	// Round-robin choice
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		if (m0_req_i.cyc && m1_req_i.cyc) begin
			grant = ~last_q;			// Other one goes first.
		end else if (m1_req_i.cyc) begin
			grant = master_id_t'(1);
		end else begin
			grant = master_id_t'(0);
		end
	end

	assign owner_cyc = (owner_q == master_id_t'(1)) ? m1_req_i.cyc : m0_req_i.cyc;

	// Owner is held for the whole cycle and dropped when its cyc goes low.
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			own_vld_q <= 1'b0;
			owner_q   <= master_id_t'(0);
			last_q    <= master_id_t'(1);	// Master 0 wins first.
		end else if (own_vld_q) begin
			if (!owner_cyc)
				own_vld_q <= 1'b0;
		end else if (m0_req_i.cyc || m1_req_i.cyc) begin
			own_vld_q <= 1'b1;
			owner_q   <= grant;
			last_q    <= grant;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Request forward and response return
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		if (!own_vld_q) begin
			bus_req_o = '0;			// Idle bus.
		end else if (owner_q == master_id_t'(1)) begin
			bus_req_o = m1_req_i;
		end else begin
			bus_req_o = m0_req_i;
		end
	end

	always_comb begin
		m0_rsp_o = '0;
		m1_rsp_o = '0;
		if (own_vld_q) begin
			if (owner_q == master_id_t'(1))
				m1_rsp_o = bus_rsp_i;
			else
				m0_rsp_o = bus_rsp_i;
		end
	end

endmodule

/* bus_decoder.sv */
`timescale 1ns/10ps

module bus_decoder import sysbus_pkg::*; (
	input  logic    clk,
	input  logic    rst_n_i,
	input  wb_req_t bus_req_i,
	input  wb_rsp_t ram_rsp_i,
	input  wb_rsp_t rom_rsp_i,
	input  wb_rsp_t text_rsp_i,
	output logic    ram_sel_o,
	output logic    rom_sel_o,
	output logic    text_sel_o,
	output wb_rsp_t bus_rsp_o
);

	logic [15:0] page;
	logic        strobe;
	logic        miss;
	logic        err_q;

	//////////////////////////////////////////////////////////////////////
	// Slave selects
	//////////////////////////////////////////////////////////////////////

	assign page   = bus_req_i.adr[31:16];
	assign strobe = bus_req_i.cyc & bus_req_i.stb;

	assign ram_sel_o  = (page == RAM_BASE);
	assign rom_sel_o  = (page == ROM_BASE);
	assign text_sel_o = (page == TEXT_BASE);

	// No slave claims this page.
	assign miss = ~(ram_sel_o | rom_sel_o | text_sel_o);

	//////////////////////////////////////////////////////////////////////
	// Unmapped access error
	//////////////////////////////////////////////////////////////////////

	// One err per strobe, same latency as a slave ack.
	always_ff @(posedge clk) begin
		if (!rst_n_i)
			err_q <= 1'b0;
		else
			err_q <= strobe & miss & ~err_q;
	end

	//////////////////////////////////////////////////////////////////////
	// Response merge
	//////////////////////////////////////////////////////////////////////

	// Idle slaves drive zeros, so a plain OR is enough.
	always_comb begin
		bus_rsp_o.ack = ram_rsp_i.ack | rom_rsp_i.ack | text_rsp_i.ack;
		bus_rsp_o.err = ram_rsp_i.err | rom_rsp_i.err | text_rsp_i.err | err_q;
		bus_rsp_o.dat = ram_rsp_i.dat | rom_rsp_i.dat | text_rsp_i.dat;
	end

endmodule

/* main_ram.sv */
`timescale 1ns/10ps

module main_ram import sysbus_pkg::*; (
	input  logic    clk,
	input  logic    rst_n_i,
	input  logic    sel_i,
	input  wb_req_t req_i,
	output wb_rsp_t rsp_o
);

	logic [63:0]       mem [RAM_WORDS];
	logic [RAM_AW-1:0] idx;
	logic              hit;
	logic              ack_q;
	logic [63:0]       rdat_q;

	assign idx = req_i.adr[3 +: RAM_AW];

	// New strobe with no ack outstanding.
	assign hit = sel_i & req_i.cyc & req_i.stb & ~ack_q;

	//////////////////////////////////////////////////////////////////////
	// Storage
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (hit && req_i.we) begin
			for (int i = 0; i < 8; i++) begin
				if (req_i.sel[i])
					mem[idx][8*i +: 8] <= req_i.dat[8*i +: 8];	// Per byte lane.
			end
		end
	end

	always_ff @(posedge clk) begin
		if (hit)
			rdat_q <= mem[idx];
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i)
			ack_q <= 1'b0;
		else
			ack_q <= hit;
	end

	always_comb begin
		rsp_o.ack = ack_q;
		rsp_o.err = 1'b0;
		rsp_o.dat = ack_q ? rdat_q : '0;	// Zero when idle.
	end

endmodule

/* boot_rom.sv */
`timescale 1ns/10ps

module boot_rom import sysbus_pkg::*; (
	input  logic    clk,
	input  logic    rst_n_i,
	input  logic    sel_i,
	input  wb_req_t req_i,
	output wb_rsp_t rsp_o
);

	logic [63:0]       mem [ROM_WORDS];
	logic [ROM_AW-1:0] idx;
	logic              hit;
	logic              ack_q;
	logic              err_q;
	logic [63:0]       rdat_q;

	// Unfilled words read as zero.
	initial begin
		for (int i = 0; i < ROM_WORDS; i++)
			mem[i] = '0;
		$readmemh(ROM_FILE, mem);
	end

	assign idx = req_i.adr[3 +: ROM_AW];
	assign hit = sel_i & req_i.cyc & req_i.stb & ~(ack_q | err_q);

	always_ff @(posedge clk) begin
		if (hit)
			rdat_q <= mem[idx];
	end

	// Writes are refused.
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			ack_q <= 1'b0;
			err_q <= 1'b0;
		end else begin
			ack_q <= hit & ~req_i.we;
			err_q <= hit & req_i.we;
		end
	end

	always_comb begin
		rsp_o.ack = ack_q;
		rsp_o.err = err_q;
		rsp_o.dat = ack_q ? rdat_q : '0;
	end

endmodule

/* text_ram.sv */
`timescale 1ns/10ps

module text_ram import sysbus_pkg::*; (
	input  logic    clk,
	input  logic    rst_n_i,
	input  logic    sel_i,
	input  wb_req_t req_i,
	output wb_rsp_t rsp_o
);

	logic [31:0]        mem [TEXT_WORDS];
	logic [TEXT_AW-1:0] idx;
	logic               half;
	logic               hit;
	logic [3:0]         lane_sel;
	bus_word_u          wword;
	bus_word_u          rword;
	logic               ack_q;
	logic               half_q;
	logic [31:0]        rdat_q;

	assign idx  = req_i.adr[2 +: TEXT_AW];
	assign half = req_i.adr[2];		// Which bus half carries the word.
	assign hit  = sel_i & req_i.cyc & req_i.stb & ~ack_q;

	assign wword.word = req_i.dat;
	assign lane_sel   = half ? req_i.sel[7:4] : req_i.sel[3:0];

	//////////////////////////////////////////////////////////////////////
	// Storage
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (hit && req_i.we) begin
			for (int i = 0; i < 4; i++) begin
				if (lane_sel[i])
					mem[idx][8*i +: 8] <= wword.half[half][8*i +: 8];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (hit) begin
			rdat_q <= mem[idx];
			half_q <= half;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i)
			ack_q <= 1'b0;
		else
			ack_q <= hit;
	end

	//////////////////////////////////////////////////////////////////////
	// Read steering
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		rword.word         = '0;
		rword.half[half_q] = rdat_q;	// Other half stays zero.
		rsp_o.ack          = ack_q;
		rsp_o.err          = 1'b0;
		rsp_o.dat          = ack_q ? rword.word : '0;
	end

endmodule

/* soc_bus_top.sv */
`timescale 1ns/10ps

module soc_bus_top import sysbus_pkg::*; (
	input  logic    clk,
	input  logic    rst_n_i,
	input  wb_req_t m0_req_i,		// CPU port.
	input  wb_req_t m1_req_i,		// Display or DMA port.
	output wb_rsp_t m0_rsp_o,
	output wb_rsp_t m1_rsp_o
);

	wb_req_t bus_req;
	wb_rsp_t bus_rsp;
	wb_rsp_t ram_rsp;
	wb_rsp_t rom_rsp;
	wb_rsp_t text_rsp;
	logic    ram_sel;
	logic    rom_sel;
	logic    text_sel;

	bus_arbiter u_arb (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.m0_req_i  (m0_req_i),
		.m1_req_i  (m1_req_i),
		.bus_rsp_i (bus_rsp),
		.bus_req_o (bus_req),
		.m0_rsp_o  (m0_rsp_o),
		.m1_rsp_o  (m1_rsp_o)
	);

	bus_decoder u_dec (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.bus_req_i  (bus_req),
		.ram_rsp_i  (ram_rsp),
		.rom_rsp_i  (rom_rsp),
		.text_rsp_i (text_rsp),
		.ram_sel_o  (ram_sel),
		.rom_sel_o  (rom_sel),
		.text_sel_o (text_sel),
		.bus_rsp_o  (bus_rsp)
	);

	main_ram u_ram (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.sel_i   (ram_sel),
		.req_i   (bus_req),
		.rsp_o   (ram_rsp)
	);

	boot_rom u_rom (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.sel_i   (rom_sel),
		.req_i   (bus_req),
		.rsp_o   (rom_rsp)
	);

	text_ram u_text (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.sel_i   (text_sel),
		.req_i   (bus_req),
		.rsp_o   (text_rsp)
	);

endmodule

/* tb_soc_bus.sv */
`timescale 1ns/10ps

module tb_soc_bus import sysbus_pkg::*; ();

	logic    clk;
	logic    rst_n;
	wb_req_t m0_req;
	wb_req_t m1_req;
	wb_rsp_t m0_rsp;
	wb_rsp_t m1_rsp;

	logic [63:0] ram_model  [RAM_WORDS];
	logic [31:0] text_model [TEXT_WORDS];
	logic [63:0] rom_model  [16];

	integer seed;
	int     errors;
	int     checks;
	int     tests;
	int     failed_tests;

	soc_bus_top UUT (
		.clk      (clk),
		.rst_n_i  (rst_n),
		.m0_req_i (m0_req),
		.m1_req_i (m1_req),
		.m0_rsp_o (m0_rsp),
		.m1_rsp_o (m1_rsp)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// Bus rules
	//////////////////////////////////////////////////////////////////////

	ack_once_m0: assert property (@(posedge clk) disable iff (!rst_n) m0_rsp.ack |=> !m0_rsp.ack)
		else begin
			$display("Bus rule broken at %0t: master 0 ack high two cycles in a row", $time);
			errors++;
		end

	ack_once_m1: assert property (@(posedge clk) disable iff (!rst_n) m1_rsp.ack |=> !m1_rsp.ack)
		else begin
			$display("Bus rule broken at %0t: master 1 ack high two cycles in a row", $time);
			errors++;
		end

	ack_err_apart: assert property (@(posedge clk) disable iff (!rst_n)
		!(m0_rsp.ack && m0_rsp.err) && !(m1_rsp.ack && m1_rsp.err))
		else begin
			$display("Bus rule broken at %0t: ack and err high together", $time);
			errors++;
		end

	// A response goes to the requesting owner only.
	owner_only_m0: assert property (@(posedge clk) disable iff (!rst_n)
		(m0_rsp != '0) |-> ($past(m0_req.cyc) && m1_rsp == '0))
		else begin
			$display("Bus rule broken at %0t: response reached a master not owning the bus", $time);
			errors++;
		end

	owner_only_m1: assert property (@(posedge clk) disable iff (!rst_n)
		(m1_rsp != '0) |-> ($past(m1_req.cyc) && m0_rsp == '0))
		else begin
			$display("Bus rule broken at %0t: response reached a master not owning the bus", $time);
			errors++;
		end

	//////////////////////////////////////////////////////////////////////
	// Master drivers and checks
	//////////////////////////////////////////////////////////////////////

	task automatic bus_cycle(input int m, input logic we, input logic [31:0] adr,
			input logic [7:0] sel, input logic [63:0] d, output wb_rsp_t rsp);
		wb_req_t req;
		int      n;
		req = '{1'b1, 1'b1, we, sel, adr, d};
		@(negedge clk);
		if (m == 0)
			m0_req = req;
		else
			m1_req = req;
		n = 0;
		rsp = '0;
		while (!(rsp.ack || rsp.err) && n < 50) begin	// 50 cycle limit.
			@(negedge clk);
			rsp = (m == 0) ? m0_rsp : m1_rsp;
			n++;
		end
		if (m == 0)
			m0_req = '0;
		else
			m1_req = '0;
		if (!(rsp.ack || rsp.err)) begin
			$display("Timeout at %0t: master %0d got no ack or err within 50 cycles", $time, m);
			errors++;
		end
	endtask

	task automatic check(input string what, input logic [65:0] got, input logic [65:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("Mismatch at %0t: %s got %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic ram_op(input int m, input logic we, input int w, input logic [7:0] sel,
			input logic [63:0] d);
		wb_rsp_t rsp;
		bus_cycle(m, we, {RAM_BASE, 16'(w * 8)}, sel, d, rsp);
		if (we) begin
			check("RAM write response", {rsp.ack, rsp.err, 64'h0}, {2'b10, 64'h0});
			for (int i = 0; i < 8; i++)
				if (sel[i])
					ram_model[w][8*i +: 8] = d[8*i +: 8];	// Byte merge.
		end else begin
			check("RAM read", rsp, {2'b10, ram_model[w]});
		end
	endtask

	task automatic text_op(input logic we, input int i, input logic [7:0] sel,
			input logic [63:0] d);
		wb_rsp_t rsp;
		int      h;
		h = i % 2;		// Odd words ride the high half.
		bus_cycle(0, we, {TEXT_BASE, 16'(i * 4)}, sel, d, rsp);
		if (we) begin
			check("text write response", {rsp.ack, rsp.err, 64'h0}, {2'b10, 64'h0});
			for (int b = 0; b < 4; b++)
				if (sel[4*h + b])
					text_model[i][8*b +: 8] = d[32*h + 8*b +: 8];
		end else begin
			check("text read", rsp, {2'b10, h ? {text_model[i], 32'h0} : {32'h0, text_model[i]}});
		end
	endtask

	// Each master keeps to its own 64 RAM words.
	task automatic traffic(input int m, input int ops);
		int w;
		for (int k = 0; k < ops; k++) begin
			w = m * 64 + ($random(seed) & 63);
			ram_op(m, 1'($random(seed)), w, 8'($random(seed)), {$random(seed), $random(seed)});
		end
	endtask

	task automatic end_test(input string name, input int mark);
		tests++;
		if (errors == mark) begin
			$display("Test %s: ok", name);
		end else begin
			failed_tests++;
			$display("Test %s: %0d errors", name, errors - mark);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		wb_rsp_t rsp;
		time     t0;
		time     t1;
		int      mark;
		seed = 32'hee46_94fe;
		errors = 0;
		checks = 0;
		tests = 0;
		failed_tests = 0;
		m0_req = '0;
		m1_req = '0;
		rst_n = 1'b0;
		$readmemh("boot_rom.hex", rom_model);

		mark = errors;
		for (int c = 0; c < 5; c++) begin
			@(negedge clk);
			rst_n = (c >= 3);		// Low for the first 3 cycles.
			check("responses around reset",
				{m0_rsp.ack, m0_rsp.err, m1_rsp.ack, m1_rsp.err, 62'h0}, 66'h0);
		end
		end_test("reset", mark);

		mark = errors;
		for (int w = 0; w < 128; w++)
			ram_op(0, 1'b1, w, 8'hFF, {16'(w), 16'hA5C3, ~16'(w), 16'(w * 3)});
		for (int k = 0; k < 64; k++)
			ram_op(0, 1'b1, $random(seed) & 31, 8'($random(seed)), {$random(seed), $random(seed)});
		for (int w = 0; w < 128; w++)
			ram_op(0, 1'b0, w, 8'hFF, 64'h0);
		end_test("RAM byte lanes", mark);

		mark = errors;
		for (int i = 0; i < 16; i++) begin
			bus_cycle(0, 1'b0, {ROM_BASE, 16'(i * 8)}, 8'hFF, 64'h0, rsp);
			check("ROM read", rsp, {2'b10, rom_model[i]});
		end
		bus_cycle(0, 1'b1, {ROM_BASE, 16'h0018}, 8'hFF, 64'hDEAD_BEEF_0BAD_F00D, rsp);
		check("ROM write response", {rsp.ack, rsp.err, 64'h0}, {2'b01, 64'h0});
		bus_cycle(0, 1'b0, {ROM_BASE, 16'h0018}, 8'hFF, 64'h0, rsp);
		check("ROM word after write", rsp, {2'b10, rom_model[3]});
		end_test("boot ROM", mark);

		mark = errors;
		for (int i = 0; i < 16; i++)
			text_op(1'b1, i, 8'hFF, {16'(i), 16'h7E00, 16'(i), 16'h0C00});
		for (int k = 0; k < 32; k++)
			text_op(1'b1, $random(seed) & 15, 8'($random(seed)), {$random(seed), $random(seed)});
		for (int i = 0; i < 16; i++)
			text_op(1'b0, i, 8'hFF, 64'h0);
		end_test("text steering", mark);

		mark = errors;
		bus_cycle(1, 1'b1, 32'h0002_0008, 8'hFF, 64'h1234_5678_9ABC_DEF0, rsp);
		check("unmapped write response", rsp, {2'b01, 64'h0});
		bus_cycle(0, 1'b0, 32'h8000_0100, 8'hFF, 64'h0, rsp);
		check("unmapped read response", rsp, {2'b01, 64'h0});
		ram_op(0, 1'b0, 1, 8'hFF, 64'h0);		// Aliased RAM word untouched.
		end_test("unmapped", mark);

		mark = errors;
		ram_op(0, 1'b0, 0, 8'hFF, 64'h0);		// Master 0 served last.
		fork
			begin
				ram_op(0, 1'b1, 40, 8'hFF, 64'h0A0A_0B0B_0C0C_0D0D);
				t0 = $time;
			end
			begin
				ram_op(1, 1'b1, 80, 8'hFF, 64'h1111_2222_3333_4444);
				t1 = $time;
			end
		join
		check("master 1 acked before master 0", {65'h0, t1 < t0}, 66'h1);
		ram_op(0, 1'b0, 40, 8'hFF, 64'h0);
		ram_op(1, 1'b0, 80, 8'hFF, 64'h0);
		fork
			traffic(0, 60);
			traffic(1, 60);
		join
		end_test("arbitration", mark);

		$display("Tests run %0d, failed %0d, checks %0d, errors %0d",
			tests, failed_tests, checks, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

/* boot_rom.hex */
// One 64-bit boot word per line, word addresses 0 to 15.
00000297F0028293
0085B50300053583
010EB6830008B603
4000006F00C5A023
FFC58593FE059EE3
0040006F00000013
123456789ABCDEF0
0F1E2D3C4B5A6978
8877665544332211
DEADBEEFCAFEF00D
0000000000000001
FFFFFFFFFFFFFFFF
A5A5A5A55A5A5A5A
0102040810204080
C0FFEE0011223344
7E57ABCDEF012345

/* sources.f */
sysbus_pkg.sv
bus_arbiter.sv
bus_decoder.sv
main_ram.sv
boot_rom.sv
text_ram.sv
soc_bus_top.sv
tb_soc_bus.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_soc_bus
FILELIST   := sources.f
BUILD_DIR  := obj_dir
FLAGS      := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
